// File: Makefile
# Verilator build and run for the hangman engine testbench.
VERILATOR ?= verilator
TOP       ?= hangmanTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/hangmanPkg.sv
// ============================================================================
// Hangman package
// State and result encodings plus the structs passed between the host
// register block, the guess filter and the game controller.
// ============================================================================
`include "hangman_macros.svh"

package hangmanPkg;

    typedef enum logic [2:0] {
        WAIT_WORD = 3'd0,
        READY     = 3'd1,
        MATCH     = 3'd2,
        WON       = 3'd3,
        LOST      = 3'd4
    } gameState_t;

    typedef enum logic [1:0] {
        RES_NONE   = 2'd0,
        RES_HIT    = 2'd1,
        RES_MISS   = 2'd2,
        RES_REPEAT = 2'd3
    } guessResult_t;

    // wishbone classic request and response.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRsp_t;

    // position 0 sits in the top byte of word.
    typedef struct packed {
        logic [`WORD_LEN*`LETTER_W-1:0] word;
        logic                           start;
        logic                           abort;
    } wordCfg_t;

    typedef struct packed {
        logic                 valid;
        logic [`LETTER_W-1:0] letter;
        logic                 isRepeat;
    } guessEvent_t;

    typedef struct packed {
        gameState_t           state;
        logic [2:0]           correct;
        logic [2:0]           mistakes;
        logic [`WORD_LEN-1:0] hitMask;
        guessResult_t         lastResult;
    } gameStatus_t;

endpackage

// File: common/hangman_macros.svh
// ============================================================================
// Hangman engine constants
// Word geometry, mistake limit and the host register map.
// ============================================================================
`ifndef HANGMAN_MACROS_SVH
`define HANGMAN_MACROS_SVH

`define WORD_LEN      5
`define LETTER_W      8
`define MAX_MISTAKES  6

// host register map, 3-bit word addresses.
`define ADR_WORD0     3'd0
`define ADR_WORD1     3'd1
`define ADR_WORD2     3'd2
`define ADR_WORD3     3'd3
`define ADR_WORD4     3'd4
`define ADR_CTRL      3'd5
`define ADR_STATUS    3'd6

`endif

// File: compile.f
+incdir+common
+incdir+dv
common/hangmanPkg.sv
game/letterMatcher.sv
game/gameController.sv
source/hostRegs.sv
source/guessFilter.sv
source/hangmanTop.sv
dv/hangmanTb.sv

// File: dv/hangmanTbTasks.svh
// ============================================================================
// Hangman testbench helpers
// Reference model of the game rules, Wishbone bus tasks and typed compares.
// ============================================================================
`ifndef HANGMAN_TB_TASKS_SVH
`define HANGMAN_TB_TASKS_SVH

// upper-case letter of a key, zero for a non-letter.
function automatic logic [7:0] foldKey(input logic [7:0] code);
    logic [7:0] up;
    up = (code >= 8'h61 && code <= 8'h7a) ? code - 8'h20 : code;
    return (up >= 8'h41 && up <= 8'h5a) ? up : 8'h00;
endfunction

function automatic hangmanPkg::gameStatus_t freshStatus(input hangmanPkg::gameState_t st);
    hangmanPkg::gameStatus_t s;
    s.state      = st;
    s.correct    = 3'd0;
    s.mistakes   = 3'd0;
    s.hitMask    = '0;
    s.lastResult = hangmanPkg::RES_NONE;
    return s;
endfunction

function automatic hangmanPkg::gameStatus_t expectStatus(
    input logic [`WORD_LEN*`LETTER_W-1:0] word,
    input logic [25:0]                    used,
    input hangmanPkg::gameStatus_t        cur,
    input logic [7:0]                     code
);
    hangmanPkg::gameStatus_t nxt;
    logic [7:0]              letter;
    logic [2:0]              cnt;
    nxt    = cur;
    letter = foldKey(code);
    cnt    = 3'd0;
    // keys are dropped outside READY.
    if (cur.state != hangmanPkg::READY || letter == 8'h00) begin
        return cur;
    end
    if (used[5'(letter - 8'h41)]) begin
        nxt.lastResult = hangmanPkg::RES_REPEAT;
        return nxt;
    end
    for (int p = 0; p < `WORD_LEN; p++) begin
        if (word[(`WORD_LEN-1-p)*`LETTER_W +: `LETTER_W] == letter
                && !cur.hitMask[p]) begin
            nxt.hitMask[p] = 1'b1;
            cnt            = cnt + 3'd1;
        end
    end
    if (cnt != 3'd0) begin
        nxt.correct    = cur.correct + cnt;
        nxt.lastResult = hangmanPkg::RES_HIT;
        nxt.state      = (&nxt.hitMask) ? hangmanPkg::WON : hangmanPkg::READY;
    end else begin
        nxt.mistakes   = cur.mistakes + 3'd1;
        nxt.lastResult = hangmanPkg::RES_MISS;
        nxt.state      = (nxt.mistakes == 3'(`MAX_MISTAKES)) ? hangmanPkg::LOST
                                                              : hangmanPkg::READY;
    end
    return nxt;
endfunction

// a letter counts as used once the engine accepts it.
function automatic logic [25:0] nextUsed(input logic [25:0] used,
                                         input hangmanPkg::gameStatus_t cur,
                                         input logic [7:0] code);
    logic [7:0]  letter;
    logic [25:0] upd;
    letter = foldKey(code);
    upd    = used;
    if (cur.state == hangmanPkg::READY && letter != 8'h00) begin
        upd[5'(letter - 8'h41)] = 1'b1;
    end
    return upd;
endfunction

// lamp pattern {ready, busy, green, red} for a state.
function automatic logic [3:0] ledsFor(input hangmanPkg::gameStatus_t s);
    return {s.state == hangmanPkg::READY, s.state == hangmanPkg::MATCH,
            s.state == hangmanPkg::WON, s.state == hangmanPkg::LOST};
endfunction

task automatic abortRun(input string reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
endtask

task automatic checkStatus(input string name, input hangmanPkg::gameStatus_t exp,
                           input hangmanPkg::gameStatus_t act);
    if (act !== exp) begin
        $display("Error at time %0t: %s expected %h got %h", $time, name, exp, act);
        abortRun("status mismatch");
    end
endtask

task automatic checkLetter(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        $display("Error at time %0t: %s expected %h got %h", $time, name, exp, act);
        abortRun("letter mismatch");
    end
endtask

task automatic checkLeds(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
        $display("Error at time %0t: %s expected %b got %b", $time, name, exp, act);
        abortRun("lamp mismatch");
    end
endtask

task automatic wbWrite(input logic [2:0] adr, input logic [31:0] dat);
    @(posedge clk);
    #1;
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    do begin
        @(posedge clk);
        #1;
    end while (!wbRsp.ack);
    wbReq = '0;
endtask

task automatic wbRead(input logic [2:0] adr, output logic [31:0] dat);
    @(posedge clk);
    #1;
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    do begin
        @(posedge clk);
        #1;
    end while (!wbRsp.ack);
    dat   = wbRsp.dat;
    wbReq = '0;
endtask

`endif

// File: dv/hangmanTb.sv
// ============================================================================
// Hangman engine testbench
// Drives the host bus and the key port and checks every guess against a
// reference model of the game rules.
// ============================================================================
`timescale 1ns/1ps
`include "hangman_macros.svh"

module hangmanTb;
    localparam int CLK_PERIOD  = 8;
    localparam int MAX_GUESSES = 520;
    localparam int MAX_BUS_OPS = 1200;
    localparam int TIMEOUT_NS  = (MAX_GUESSES * 200 + MAX_BUS_OPS * 4) * CLK_PERIOD;

    logic               clk;
    logic               nRst;
    hangmanPkg::wbReq_t wbReq;
    hangmanPkg::wbRsp_t wbRsp;
    logic               keyValid;
    logic [7:0]         keyCode;
    logic               ready;
    logic               busy;
    logic               green;
    logic               red;

    logic [`WORD_LEN*`LETTER_W-1:0] modelWord;
    logic [25:0]                    modelUsed;
    hangmanPkg::gameStatus_t        modelStatus;
    hangmanPkg::gameStatus_t        actStatus;
    integer                         seed;
    event                           checkEv;

    `include "hangmanTbTasks.svh"

    hangmanTop uut (
        .clk      (clk),
        .nRst     (nRst),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .keyValid (keyValid),
        .keyCode  (keyCode),
        .ready    (ready),
        .busy     (busy),
        .green    (green),
        .red      (red)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the game engine did not finish within %0d ns.", TIMEOUT_NS);
        abortRun("watchdog timeout");
    end

    // compares each status read with the model.
    initial begin
        forever begin
            @(checkEv);
            checkStatus("status", modelStatus, actStatus);
            checkLeds("ready/busy/green/red", ledsFor(modelStatus),
                      {ready, busy, green, red});
        end
    end

    task automatic sampleStatus();
        logic [31:0] rd;
        wbRead(`ADR_STATUS, rd);
        actStatus = hangmanPkg::gameStatus_t'(rd[15:0]);
        ->checkEv;
    endtask

    task automatic loadWord(input logic [`WORD_LEN*`LETTER_W-1:0] word);
        for (int i = 0; i < `WORD_LEN; i++) begin
            wbWrite(3'(i), {24'h0, word[(`WORD_LEN-1-i)*`LETTER_W +: `LETTER_W]});
        end
        modelWord = word;
    endtask

    task automatic startGame();
        wbWrite(`ADR_CTRL, 32'h1);
        modelStatus = freshStatus(hangmanPkg::READY);
        modelUsed   = '0;
        sampleStatus();
    endtask

    task automatic abortGame();
        wbWrite(`ADR_CTRL, 32'h2);
        modelStatus = freshStatus(hangmanPkg::WAIT_WORD);
        sampleStatus();
    endtask

    task automatic sendKey(input logic [7:0] code);
        @(posedge clk);
        #1;
        keyValid = 1'b1;
        keyCode  = code;
        @(posedge clk);
        #1;
        keyValid = 1'b0;
    endtask

    task automatic pressKey(input logic [7:0] code);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        sendKey(code);
    endtask

    task automatic guessKey(input logic [7:0] code);
        hangmanPkg::gameStatus_t exp;
        hangmanPkg::gameStatus_t mid;
        logic [25:0]             usedNext;
        usedNext = nextUsed(modelUsed, modelStatus, code);
        exp      = expectStatus(modelWord, modelUsed, modelStatus, code);
        mid      = modelStatus;
        // a letter not used before starts a match.
        if (usedNext != modelUsed) begin
            mid.state = hangmanPkg::MATCH;
        end
        modelUsed = usedNext;
        if (modelStatus.state == hangmanPkg::READY) begin
            pressKey(code);
            // busy rises one cycle after the guess event.
            @(posedge clk);
            #1;
            checkLeds("ready/busy/green/red", ledsFor(mid), {ready, busy, green, red});
            while (busy) begin
                @(posedge clk);
                #1;
            end
        end else begin
            // key is lost while the engine is not ready.
            sendKey(code);
            repeat (10) @(posedge clk);
            #1;
        end
        modelStatus = exp;
        sampleStatus();
    endtask

    function automatic logic [7:0] keyFor(input int pick);
        if (pick < 8) begin
            return 8'(8'h41 + pick);
        end else if (pick < 16) begin
            return 8'(8'h61 + pick - 8);
        end
        return 8'(8'h20 + pick);
    endfunction

    initial begin
        logic [31:0]                    rd;
        logic [`WORD_LEN*`LETTER_W-1:0] word;
        int                             pick;
        seed        = 32'h19;
        nRst        = 1'b0;
        wbReq       = '0;
        keyValid    = 1'b0;
        keyCode     = 8'h00;
        modelWord   = '0;
        modelUsed   = '0;
        modelStatus = freshStatus(hangmanPkg::WAIT_WORD);
        repeat (5) @(posedge clk);
        #1;
        nRst = 1'b1;

        // register readback, reset and abort.
        sampleStatus();
        loadWord("APPLE");
        for (int i = 0; i < `WORD_LEN; i++) begin
            wbRead(3'(i), rd);
            checkLetter("word letter", modelWord[(`WORD_LEN-1-i)*`LETTER_W +: `LETTER_W],
                        rd[7:0]);
        end
        startGame();
        guessKey("A");
        abortGame();

        // hits with a double letter, then six misses.
        startGame();
        guessKey("P");
        guessKey("A");
        guessKey("X");
        guessKey("Y");
        guessKey("Z");
        guessKey("Q");
        guessKey("W");
        guessKey("K");
        guessKey("L");

        // case folding, non-letters, repeats and a win.
        startGame();
        guessKey("p");
        guessKey("5");
        guessKey("P");
        guessKey("a");
        guessKey("L");
        guessKey("e");
        guessKey("Z");
        startGame();
        guessKey("P");

        // random games over a small alphabet.
        for (int g = 0; g < 20; g++) begin
            for (int i = 0; i < `WORD_LEN; i++) begin
                word[(`WORD_LEN-1-i)*`LETTER_W +: `LETTER_W] = 8'(8'h41 + {$random(seed)} % 6);
            end
            loadWord(word);
            startGame();
            for (int k = 0; k < 24 && modelStatus.state == hangmanPkg::READY; k++) begin
                pick = {$random(seed)} % 20;
                guessKey(keyFor(pick));
            end
        end

        // last status compare runs before the verdict.
        @(posedge clk);
        #1;
        $display("Test passed");
        $finish;
    end

endmodule

// File: game/gameController.sv
// ============================================================================
// Game controller
// FSM that starts and aborts games, runs the letter matcher for each fresh
// guess, keeps score and decides win or loss.
// ============================================================================
`timescale 1ns/1ps
`include "hangman_macros.svh"

module gameController (
    input  logic                     clk,
    input  logic                     nRst,
    input  hangmanPkg::wordCfg_t     cfg,
    input  hangmanPkg::guessEvent_t  guess,
    output logic                     ready,
    output logic                     busy,
    output logic                     green,
    output logic                     red,
    output hangmanPkg::gameStatus_t  status
);
    localparam hangmanPkg::gameStatus_t STATUS_CLEAR = '{
        state:      hangmanPkg::WAIT_WORD,
        correct:    3'd0,
        mistakes:   3'd0,
        hitMask:    '0,
        lastResult: hangmanPkg::RES_NONE
    };

    hangmanPkg::gameStatus_t stat;
    hangmanPkg::gameStatus_t statNext;
    logic                    matchStart;
    logic                    matchDone;
    logic [`WORD_LEN-1:0]    newMask;
    logic [2:0]              newCount;
    logic [`WORD_LEN-1:0]    mergedMask;

    letterMatcher matcher (
        .clk        (clk),
        .nRst       (nRst),
        .matchStart (matchStart),
        .letter     (guess.letter),
        .word       (cfg.word),
        .foundMask  (stat.hitMask),
        .matchDone  (matchDone),
        .newMask    (newMask),
        .newCount   (newCount)
    );

    assign mergedMask = stat.hitMask | newMask;

    always_comb begin
        statNext   = stat;
        matchStart = 1'b0;

        case (stat.state)
            hangmanPkg::READY: begin
                if (guess.valid) begin
                    if (guess.isRepeat) begin
                        statNext.lastResult = hangmanPkg::RES_REPEAT;
                    end else begin
                        statNext.state = hangmanPkg::MATCH;
                        matchStart     = 1'b1;
                    end
                end
            end
            hangmanPkg::MATCH: begin
                if (matchDone) begin
                    if (newCount != 3'd0) begin
                        statNext.hitMask    = mergedMask;
                        statNext.correct    = stat.correct + newCount;
                        statNext.lastResult = hangmanPkg::RES_HIT;
                        statNext.state      = (&mergedMask) ? hangmanPkg::WON
                                                            : hangmanPkg::READY;
                    end else begin
                        statNext.mistakes   = stat.mistakes + 3'd1;
                        statNext.lastResult = hangmanPkg::RES_MISS;
                        if (statNext.mistakes == 3'(`MAX_MISTAKES)) begin
                            statNext.state = hangmanPkg::LOST;
                        end else begin
                            statNext.state = hangmanPkg::READY;
                        end
                    end
                end
            end
            default: ;
        endcase

        // host strobes override the game, abort first.
        if (cfg.abort) begin
            statNext   = STATUS_CLEAR;
            matchStart = 1'b0;
        end else if (cfg.start) begin
            statNext       = STATUS_CLEAR;
            statNext.state = hangmanPkg::READY;
            matchStart     = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            stat <= STATUS_CLEAR;
        end else begin
            stat <= statNext;
        end
    end

    assign ready  = (stat.state == hangmanPkg::READY);
    assign busy   = (stat.state == hangmanPkg::MATCH);
    assign green  = (stat.state == hangmanPkg::WON);
    assign red    = (stat.state == hangmanPkg::LOST);
    assign status = stat;

endmodule

// File: game/letterMatcher.sv
// ============================================================================
// Letter matcher
// Walks the word one position per cycle and collects every position that
// holds the guessed letter and was not found before.
// ============================================================================
`timescale 1ns/1ps
`include "hangman_macros.svh"

module letterMatcher (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           matchStart,
    input  logic [`LETTER_W-1:0]           letter,
    input  logic [`WORD_LEN*`LETTER_W-1:0] word,
    input  logic [`WORD_LEN-1:0]           foundMask,
    output logic                           matchDone,
    output logic [`WORD_LEN-1:0]           newMask,
    output logic [2:0]                     newCount
);
    localparam logic [2:0] LAST_POS = 3'(`WORD_LEN - 1);

    logic [`WORD_LEN*`LETTER_W-1:0] wordQ;
    logic [`LETTER_W-1:0]           letterQ;
    logic [`WORD_LEN-1:0]           foundQ;
    logic [2:0]                     posQ;
    logic                           active;
    logic                           doneQ;
    logic                           hit;

    // top byte of the shifted word is the current position.
    assign hit = active && !foundQ[posQ]
              && (wordQ[`WORD_LEN*`LETTER_W-1 -: `LETTER_W] == letterQ);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            active <= 1'b0;
            doneQ  <= 1'b0;
            posQ   <= '0;
        end else begin
            doneQ <= 1'b0;
            if (matchStart) begin
                active <= 1'b1;
                posQ   <= '0;
            end else if (active) begin
                posQ <= posQ + 3'd1;
                if (posQ == LAST_POS) begin
                    active <= 1'b0;
                    doneQ  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (matchStart) begin
            wordQ    <= word;
            letterQ  <= letter;
            foundQ   <= foundMask;
            newMask  <= '0;
            newCount <= '0;
        end else if (active) begin
            wordQ <= wordQ << `LETTER_W;
            if (hit) begin
                newMask[posQ] <= 1'b1;
                newCount      <= newCount + 3'd1;
            end
        end
    end

    assign matchDone = doneQ;

endmodule

// File: source/guessFilter.sv
// ============================================================================
// Guess filter
// Folds key codes to upper case, drops non-letters and flags letters
// already guessed in the current game.
// ============================================================================
`timescale 1ns/1ps
`include "hangman_macros.svh"

module guessFilter (
    input  logic                      clk,
    input  logic                      nRst,
    input  logic                      keyValid,
    input  logic [7:0]                keyCode,
    input  logic                      ready,
    input  logic                      clearUsed,
    output hangmanPkg::guessEvent_t   guess
);
    localparam logic [7:0] UPPER_A     = 8'h41;
    localparam logic [7:0] UPPER_Z     = 8'h5a;
    localparam logic [7:0] LOWER_A     = 8'h61;
    localparam logic [7:0] LOWER_Z     = 8'h7a;
    localparam logic [7:0] CASE_OFFSET = 8'h20;

    logic [`LETTER_W-1:0] folded;
    logic                 isLetter;
    logic [4:0]           idx;
    logic                 accept;
    logic [25:0]          used;
    logic                 validQ;
    logic [`LETTER_W-1:0] letterQ;
    logic                 repeatQ;

    always_comb begin
        folded = keyCode;
        if (keyCode >= LOWER_A && keyCode <= LOWER_Z) begin
            folded = keyCode - CASE_OFFSET;
        end
        isLetter = (folded >= UPPER_A) && (folded <= UPPER_Z);
        idx      = 5'(folded - UPPER_A);
    end

    // one event in flight at most.
    assign accept = keyValid && ready && !validQ && isLetter;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            validQ <= 1'b0;
            used   <= '0;
        end else begin
            validQ <= accept;
            if (clearUsed) begin
                used <= '0;
            end else if (accept) begin
                used[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            letterQ <= folded;
            repeatQ <= used[idx] && !clearUsed;
        end
    end

    assign guess = '{valid: validQ, letter: letterQ, isRepeat: repeatQ};

endmodule

// File: source/hangmanTop.sv
// ============================================================================
// Hangman engine top
// Host registers and guess filter feed the game controller.
// ============================================================================
`timescale 1ns/1ps

module hangmanTop (
    input  logic                clk,
    input  logic                nRst,
    input  hangmanPkg::wbReq_t  wbReq,
    output hangmanPkg::wbRsp_t  wbRsp,
    input  logic                keyValid,
    input  logic [7:0]          keyCode,
    output logic                ready,
    output logic                busy,
    output logic                green,
    output logic                red
);
    hangmanPkg::wordCfg_t    cfg;
    hangmanPkg::gameStatus_t status;
    hangmanPkg::guessEvent_t guess;

    hostRegs regs (
        .clk    (clk),
        .nRst   (nRst),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .cfg    (cfg),
        .status (status)
    );

    // a new game forgets the letters used so far.
    guessFilter filter (
        .clk       (clk),
        .nRst      (nRst),
        .keyValid  (keyValid),
        .keyCode   (keyCode),
        .ready     (ready),
        .clearUsed (cfg.start),
        .guess     (guess)
    );

    gameController ctrl (
        .clk    (clk),
        .nRst   (nRst),
        .cfg    (cfg),
        .guess  (guess),
        .ready  (ready),
        .busy   (busy),
        .green  (green),
        .red    (red),
        .status (status)
    );

endmodule

// File: source/hostRegs.sv
// ============================================================================
// Host register block
// Wishbone classic slave with the five word letters, the start and abort
// strobes and a readback of the game status. Single-cycle ack, no waits.
// ============================================================================
`timescale 1ns/1ps
`include "hangman_macros.svh"

module hostRegs (
    input  logic                     clk,
    input  logic                     nRst,
    input  hangmanPkg::wbReq_t       wbReq,
    output hangmanPkg::wbRsp_t       wbRsp,
    output hangmanPkg::wordCfg_t     cfg,
    input  hangmanPkg::gameStatus_t  status
);
    logic [`LETTER_W-1:0] letters [`WORD_LEN];
    logic                 ackQ;
    logic                 startQ;
    logic                 abortQ;
    logic [31:0]          datQ;
    logic [31:0]          readData;
    logic                 access;

    // new transfer only while ack is low.
    assign access = wbReq.cyc && wbReq.stb && !ackQ;

    always_comb begin
        readData = '0;
        unique case (wbReq.adr)
            `ADR_WORD0:  readData[`LETTER_W-1:0] = letters[0];
            `ADR_WORD1:  readData[`LETTER_W-1:0] = letters[1];
            `ADR_WORD2:  readData[`LETTER_W-1:0] = letters[2];
            `ADR_WORD3:  readData[`LETTER_W-1:0] = letters[3];
            `ADR_WORD4:  readData[`LETTER_W-1:0] = letters[4];
            `ADR_STATUS: readData[$bits(hangmanPkg::gameStatus_t)-1:0] = status;
            default:     readData = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ackQ   <= 1'b0;
            startQ <= 1'b0;
            abortQ <= 1'b0;
            for (int i = 0; i < `WORD_LEN; i++) begin
                letters[i] <= '0;
            end
        end else begin
            ackQ   <= access;
            startQ <= 1'b0;
            abortQ <= 1'b0;
            if (access && wbReq.we) begin
                unique case (wbReq.adr)
                    `ADR_WORD0: letters[0] <= wbReq.dat[`LETTER_W-1:0];
                    `ADR_WORD1: letters[1] <= wbReq.dat[`LETTER_W-1:0];
                    `ADR_WORD2: letters[2] <= wbReq.dat[`LETTER_W-1:0];
                    `ADR_WORD3: letters[3] <= wbReq.dat[`LETTER_W-1:0];
                    `ADR_WORD4: letters[4] <= wbReq.dat[`LETTER_W-1:0];
                    `ADR_CTRL: begin
                        startQ <= wbReq.dat[0];
                        abortQ <= wbReq.dat[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data is captured with the ack.
    always_ff @(posedge clk) begin
        if (access && !wbReq.we) begin
            datQ <= readData;
        end
    end

    always_comb begin
        for (int i = 0; i < `WORD_LEN; i++) begin
            cfg.word[(`WORD_LEN-1-i)*`LETTER_W +: `LETTER_W] = letters[i];
        end
        cfg.start = startQ;
        cfg.abort = abortQ;
    end

    assign wbRsp.ack = ackQ;
    assign wbRsp.dat = datQ;

endmodule
